// ==== tests/tcb_patterns.txt ====
// grp port wen adr siz ndn wdt exp_rdt exp_sts  (hex, ndn 1 = big endian)
// lines with the same grp are issued together, one line per port
00 0 1 00000000 2 0 11223344 00000000 0
01 0 0 00000000 2 0 00000000 11223344 0
02 1 1 00000004 2 0 cafef00d 00000000 0
03 1 0 00000004 2 0 00000000 cafef00d 0
04 0 0 00000000 2 1 00000000 44332211 0
05 0 1 00000010 2 0 8899aabb 00000000 0
06 0 1 00000011 0 0 000000e1 00000000 0
07 1 1 00000013 0 1 000000f3 00000000 0
08 0 0 00000010 2 0 00000000 f399e1bb 0
09 0 1 00000014 2 0 55667788 00000000 0
0a 0 1 00000016 1 0 0000beef 00000000 0
0b 1 1 00000014 1 1 0000c3d4 00000000 0
0c 0 0 00000014 2 0 00000000 beefd4c3 0
0d 0 1 00000020 2 0 d4c3b2a1 00000000 0
0e 0 0 00000020 0 0 00000000 000000a1 0
0f 1 0 00000021 0 1 00000000 000000b2 0
10 0 0 00000022 0 0 00000000 000000c3 0
11 1 0 00000023 0 1 00000000 000000d4 0
12 0 0 00000020 1 0 00000000 0000b2a1 0
13 0 0 00000022 1 0 00000000 0000d4c3 0
14 1 0 00000020 1 1 00000000 0000a1b2 0
15 1 0 00000022 1 1 00000000 0000c3d4 0
16 0 0 00000023 1 0 00000000 0000a1d4 0
17 1 0 00000021 2 0 00000000 a1d4c3b2 0
18 0 0 00000023 2 1 00000000 d4a1b2c3 0
19 1 1 00000026 2 0 44332211 00000000 0
1a 1 0 00000024 2 0 00000000 22114433 0
1b 0 1 00000027 1 1 00009a8b 00000000 0
1c 0 0 00000024 2 0 00000000 9a11448b 0
1d 0 1 00000028 2 0 0badf00d 00000000 0
1d 1 1 00000030 2 0 600dcafe 00000000 0
1e 0 0 00000030 2 0 00000000 600dcafe 0
1e 1 0 00000028 2 0 00000000 0badf00d 0
1f 0 0 00000021 0 0 00000000 000000b2 0
1f 1 0 00000010 1 1 00000000 0000bbe1 0
20 0 1 00000030 0 0 00000034 00000000 0
20 1 1 00000032 0 1 00000056 00000000 0
21 1 0 00000030 2 0 00000000 6056ca34 0
21 0 0 0000002a 1 1 00000000 0000ad0b 0
22 0 1 00000400 2 0 deadbeef 00000000 1
23 0 0 00000400 2 0 00000000 00000000 1
24 0 0 000007fe 1 0 00000000 00000000 1
24 1 0 00000000 2 0 00000000 11223344 0

// ==== list.f ====
hw/tcb_pkg.sv
hw/tcb_logsize2byteena.sv
hw/tcb_arbiter.sv
hw/tcb_sram.sv
hw/tcb_subsystem_top.sv
tests/tcb_subsystem_tb.sv

// ==== Makefile ====
# Verilator build and run for the bus subsystem testbench

VERILATOR ?= verilator
TOP       ?= tcb_subsystem_tb
FILELIST  ?= list.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when the file list or a source changes
$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the log holds the pass line
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/tcb_subsystem_tb.sv ====
////////////////////////////////////////
// testbench for the two port bus subsystem
// replays tests/tcb_patterns.txt group by group
// and checks every response field
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tcb_subsystem_tb;

  import tcb_pkg::*;

  localparam int          PERIOD    = 20;
  localparam int          DRIVE_DLY = 2;
  localparam int          TIMEOUT   = 50;
  localparam int          MAX_TXN   = 64;
  localparam int          NCOL      = 9;
  localparam int unsigned MEM_WORDS = 256;
  localparam logic [15:0] SEED      = 16'd48979;

  // pattern columns
  localparam int COL_GRP  = 0;
  localparam int COL_PORT = 1;
  localparam int COL_WEN  = 2;
  localparam int COL_ADR  = 3;
  localparam int COL_SIZ  = 4;
  localparam int COL_NDN  = 5;
  localparam int COL_WDT  = 6;
  localparam int COL_RDT  = 7;
  localparam int COL_STS  = 8;

  logic clk;
  logic arst_n;

  // manager 0
  logic     m0_vld, m0_rdy, m0_wen, m0_rsp_vld;
  tcb_adr_t m0_adr;
  tcb_siz_t m0_siz;
  tcb_ndn_t m0_ndn;
  tcb_dat_t m0_wdt, m0_rdt;
  tcb_sts_t m0_sts;

  // manager 1
  logic     m1_vld, m1_rdy, m1_wen, m1_rsp_vld;
  tcb_adr_t m1_adr;
  tcb_siz_t m1_siz;
  tcb_ndn_t m1_ndn;
  tcb_dat_t m1_wdt, m1_rdt;
  tcb_sts_t m1_sts;

  // flat pattern table with NCOL words per transaction
  logic [31:0] pat [NCOL*MAX_TXN];
  logic [15:0] lfsr;
  // handshakes due at the next rising edge per port
  logic [1:0]  hsk_pend;

  tcb_subsystem_top #(
    .MEM_WORDS (MEM_WORDS)
  ) DUT (
    .clk, .arst_n,
    .m0_vld, .m0_rdy, .m0_wen, .m0_adr, .m0_siz, .m0_ndn, .m0_wdt,
    .m0_rsp_vld, .m0_rdt, .m0_sts,
    .m1_vld, .m1_rdy, .m1_wen, .m1_adr, .m1_siz, .m1_ndn, .m1_wdt,
    .m1_rsp_vld, .m1_rdt, .m1_sts
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

////////////////////////////////////////
// helpers
////////////////////////////////////////

  function automatic logic [31:0] field(input int k, input int col);
    return pat[NCOL*k + col];
  endfunction

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic port_rdy(input int port);
    return (port != 0) ? m1_rdy : m0_rdy;
  endfunction

  function automatic logic port_rsp_vld(input int port);
    return (port != 0) ? m1_rsp_vld : m0_rsp_vld;
  endfunction

  function automatic logic [31:0] port_rdt(input int port);
    return (port != 0) ? m1_rdt : m0_rdt;
  endfunction

  function automatic logic [31:0] port_sts(input int port);
    return (port != 0) ? {31'd0, m1_sts} : {31'd0, m0_sts};
  endfunction

  task automatic finish_failed();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    finish_failed();
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: time %0t: %s got %h expected %h", $time, what, got, exp);
      finish_failed();
    end
  endtask

  // put pattern k on its port with vld high
  task automatic drive_port(input int port, input int k);
    if (port != 0) begin
      m1_wen = (field(k, COL_WEN) != 0);
      m1_adr = field(k, COL_ADR);
      m1_siz = tcb_siz_t'(field(k, COL_SIZ));
      m1_ndn = (field(k, COL_NDN) != 0) ? tcb_big : tcb_little;
      m1_wdt = field(k, COL_WDT);
      m1_vld = 1'b1;
    end else begin
      m0_wen = (field(k, COL_WEN) != 0);
      m0_adr = field(k, COL_ADR);
      m0_siz = tcb_siz_t'(field(k, COL_SIZ));
      m0_ndn = (field(k, COL_NDN) != 0) ? tcb_big : tcb_little;
      m0_wdt = field(k, COL_WDT);
      m0_vld = 1'b1;
    end
  endtask

  // one transaction where waits counts cycles with rdy low
  task automatic run_txn(input int k, output int waits);
    int port;
    int lat;
    port  = int'(field(k, COL_PORT));
    waits = 0;
    lat   = 0;
    drive_port(port, k);
    // rdy is combinational and stable by mid cycle
    @(negedge clk);
    while (!port_rdy(port)) begin
      waits++;
      if (waits > TIMEOUT) abort_run($sformatf("port %0d never saw rdy", port));
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DLY;
    if (port != 0) m1_vld = 1'b0;
    else m0_vld = 1'b0;
    // response should show on the very next cycle
    do begin
      @(negedge clk);
      lat++;
      if (lat > TIMEOUT) abort_run($sformatf("port %0d never saw rsp_vld", port));
    end while (!port_rsp_vld(port));
    check_value($sformatf("port %0d response latency", port), lat, 1);
    check_value($sformatf("port %0d sts", port), port_sts(port), field(k, COL_STS));
    // write response data is don't care
    if (field(k, COL_WEN) == 0) begin
      check_value($sformatf("port %0d rdt", port), port_rdt(port), field(k, COL_RDT));
    end
  endtask

////////////////////////////////////////
// response pulse monitor
////////////////////////////////////////

  // rsp_vld is high only on the cycle after a handshake on its own port
  always @(negedge clk) begin
    if (arst_n) begin
      check_value("port 0 rsp_vld", {31'd0, m0_rsp_vld}, {31'd0, hsk_pend[0]});
      check_value("port 1 rsp_vld", {31'd0, m1_rsp_vld}, {31'd0, hsk_pend[1]});
    end
    // vld and rdy hold from here to the next rising edge
    hsk_pend[0] = m0_vld && m0_rdy;
    hsk_pend[1] = m1_vld && m1_rdy;
  end

////////////////////////////////////////
// main sequence
////////////////////////////////////////

  initial begin
    int          k;
    int          n;
    int          p;
    int          w0;
    int          w1;
    int          slot [2];
    logic [31:0] grp;
    logic [1:0]  idle;
    arst_n   = 1'b0;
    m0_vld   = 1'b0;
    m0_wen   = 1'b0;
    m0_adr   = '0;
    m0_siz   = '0;
    m0_ndn   = tcb_little;
    m0_wdt   = '0;
    m1_vld   = 1'b0;
    m1_wen   = 1'b0;
    m1_adr   = '0;
    m1_siz   = '0;
    m1_ndn   = tcb_little;
    m1_wdt   = '0;
    hsk_pend = '0;
    lfsr     = SEED;
    // all ones marks the end of the table
    for (int i = 0; i < NCOL*MAX_TXN; i++) pat[i] = '1;
    $readmemh("tests/tcb_patterns.txt", pat);
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    k = 0;
    n = 0;
    while (k < MAX_TXN && field(k, COL_GRP) != '1) begin
      // gather one group with at most one line per port
      grp     = field(k, COL_GRP);
      slot[0] = -1;
      slot[1] = -1;
      while (k < MAX_TXN && field(k, COL_GRP) == grp) begin
        p = int'(field(k, COL_PORT));
        if (p > 1 || slot[p] >= 0) abort_run($sformatf("bad pattern line %0d", k));
        slot[p] = k;
        k++;
        n++;
      end
      w0 = 0;
      w1 = 0;
      fork
        begin
          if (slot[0] >= 0) run_txn(slot[0], w0);
        end
        begin
          if (slot[1] >= 0) run_txn(slot[1], w1);
        end
      join
      // one grant per cycle and the loser goes next
      check_value("rdy wait cycles", w0 + w1, (slot[0] >= 0 && slot[1] >= 0) ? 1 : 0);
      // 0 to 3 idle cycles with one lfsr step per bit
      for (int b = 0; b < 2; b++) begin
        lfsr    = lfsr_step(lfsr);
        idle[b] = lfsr[0];
      end
      repeat (idle) @(posedge clk);
      @(posedge clk);
      #DRIVE_DLY;
    end
    if (n == 0) begin
      abort_run("pattern file held no transactions");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== hw/tcb_subsystem_top.sv ====
////////////////////////////////////////
// two log size managers sharing one SRAM
// converters, round robin arbiter and memory
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tcb_subsystem_top #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic              clk,
  input  logic              arst_n,
  // manager 0
  input  logic              m0_vld,
  output logic              m0_rdy,
  input  logic              m0_wen,
  input  tcb_pkg::tcb_adr_t m0_adr,
  input  tcb_pkg::tcb_siz_t m0_siz,
  input  tcb_pkg::tcb_ndn_t m0_ndn,
  input  tcb_pkg::tcb_dat_t m0_wdt,
  output logic              m0_rsp_vld,
  output tcb_pkg::tcb_dat_t m0_rdt,
  output tcb_pkg::tcb_sts_t m0_sts,
  // manager 1
  input  logic              m1_vld,
  output logic              m1_rdy,
  input  logic              m1_wen,
  input  tcb_pkg::tcb_adr_t m1_adr,
  input  tcb_pkg::tcb_siz_t m1_siz,
  input  tcb_pkg::tcb_ndn_t m1_ndn,
  input  tcb_pkg::tcb_dat_t m1_wdt,
  output logic              m1_rsp_vld,
  output tcb_pkg::tcb_dat_t m1_rdt,
  output tcb_pkg::tcb_sts_t m1_sts
);

  import tcb_pkg::*;

////////////////////////////////////////
// byte enable buses, converter to arbiter
////////////////////////////////////////

  logic     b0_vld, b0_rdy, b0_wen, b0_rsp_vld;
  tcb_adr_t b0_adr;
  tcb_ben_t b0_ben;
  tcb_dat_t b0_wdt, b0_rdt;
  tcb_sts_t b0_sts;

  logic     b1_vld, b1_rdy, b1_wen, b1_rsp_vld;
  tcb_adr_t b1_adr;
  tcb_ben_t b1_ben;
  tcb_dat_t b1_wdt, b1_rdt;
  tcb_sts_t b1_sts;

  // shared bus, arbiter to memory
  logic     mem_vld, mem_rdy, mem_wen, mem_rsp_vld;
  tcb_adr_t mem_adr;
  tcb_ben_t mem_ben;
  tcb_dat_t mem_wdt, mem_rdt;
  tcb_sts_t mem_sts;

  // manager 0 converter
  tcb_logsize2byteena u_cnv0 (
    .clk, .arst_n,
    .sub_vld (m0_vld), .sub_rdy (m0_rdy), .sub_wen (m0_wen), .sub_adr (m0_adr),
    .sub_siz (m0_siz), .sub_ndn (m0_ndn), .sub_wdt (m0_wdt),
    .sub_rsp_vld (m0_rsp_vld), .sub_rdt (m0_rdt), .sub_sts (m0_sts),
    .man_vld (b0_vld), .man_rdy (b0_rdy), .man_wen (b0_wen), .man_adr (b0_adr),
    .man_ben (b0_ben), .man_wdt (b0_wdt),
    .man_rsp_vld (b0_rsp_vld), .man_rdt (b0_rdt), .man_sts (b0_sts)
  );

  // manager 1 converter
  tcb_logsize2byteena u_cnv1 (
    .clk, .arst_n,
    .sub_vld (m1_vld), .sub_rdy (m1_rdy), .sub_wen (m1_wen), .sub_adr (m1_adr),
    .sub_siz (m1_siz), .sub_ndn (m1_ndn), .sub_wdt (m1_wdt),
    .sub_rsp_vld (m1_rsp_vld), .sub_rdt (m1_rdt), .sub_sts (m1_sts),
    .man_vld (b1_vld), .man_rdy (b1_rdy), .man_wen (b1_wen), .man_adr (b1_adr),
    .man_ben (b1_ben), .man_wdt (b1_wdt),
    .man_rsp_vld (b1_rsp_vld), .man_rdt (b1_rdt), .man_sts (b1_sts)
  );

  // round robin between the two converters
  tcb_arbiter u_arb (
    .clk, .arst_n,
    .p0_vld (b0_vld), .p0_rdy (b0_rdy), .p0_wen (b0_wen), .p0_adr (b0_adr),
    .p0_ben (b0_ben), .p0_wdt (b0_wdt),
    .p0_rsp_vld (b0_rsp_vld), .p0_rdt (b0_rdt), .p0_sts (b0_sts),
    .p1_vld (b1_vld), .p1_rdy (b1_rdy), .p1_wen (b1_wen), .p1_adr (b1_adr),
    .p1_ben (b1_ben), .p1_wdt (b1_wdt),
    .p1_rsp_vld (b1_rsp_vld), .p1_rdt (b1_rdt), .p1_sts (b1_sts),
    .mem_vld, .mem_rdy, .mem_wen, .mem_adr, .mem_ben, .mem_wdt,
    .mem_rsp_vld, .mem_rdt, .mem_sts
  );

  // shared memory
  tcb_sram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_sram (
    .clk, .arst_n,
    .mem_vld, .mem_rdy, .mem_wen, .mem_adr, .mem_ben, .mem_wdt,
    .mem_rsp_vld, .mem_rdt, .mem_sts
  );

endmodule

`default_nettype wire

// ==== hw/tcb_sram.sv ====
////////////////////////////////////////
// single port byte enable SRAM, one cycle read latency
// words past MEM_WORDS answer with an error status
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tcb_sram #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              mem_vld,
  output logic              mem_rdy,
  input  logic              mem_wen,
  input  tcb_pkg::tcb_adr_t mem_adr,
  input  tcb_pkg::tcb_ben_t mem_ben,
  input  tcb_pkg::tcb_dat_t mem_wdt,
  output logic              mem_rsp_vld,
  output tcb_pkg::tcb_dat_t mem_rdt,
  output tcb_pkg::tcb_sts_t mem_sts
);

  import tcb_pkg::*;

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  // storage array
  tcb_dat_t mem [MEM_WORDS];

  // word address, byte offset dropped
  logic [$bits(tcb_adr_t)-3:0] wrd;
  logic [IDX_W-1:0]            idx;
  logic                        hit;
  logic                        hsk;

  // always ready, no wait states
  assign mem_rdy = 1'b1;
  assign hsk     = mem_vld && mem_rdy;

  assign wrd = mem_adr[$bits(tcb_adr_t)-1:2];
  assign idx = wrd[IDX_W-1:0];
  assign hit = (wrd < MEM_WORDS);

  // write per byte lane, read full word
  always_ff @(posedge clk) begin
    if (hsk && hit) begin
      if (mem_wen) begin
        for (int unsigned i = 0; i < TCB_BEN; i++) begin
          if (mem_ben[i]) begin
            mem[idx][8*i +: 8] <= mem_wdt[8*i +: 8];
          end
        end
      end
    end
    if (hsk) begin
      mem_rdt <= hit ? mem[idx] : '0;
      mem_sts <= hit ? tcb_sts_ok : tcb_sts_err;
    end
  end

  // response one cycle after the handshake
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_rsp_vld <= 1'b0;
    end else begin
      mem_rsp_vld <= hsk;
    end
  end

  // converter always sets at least one lane
  ben_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
    hsk |-> (mem_ben != '0));

endmodule

`default_nettype wire

// ==== hw/tcb_arbiter.sv ====
////////////////////////////////////////
// two port round robin arbiter onto one byte enable bus
// responses follow the grant of the previous cycle
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tcb_arbiter (
  input  logic              clk,
  input  logic              arst_n,
  // port 0
  input  logic              p0_vld,
  output logic              p0_rdy,
  input  logic              p0_wen,
  input  tcb_pkg::tcb_adr_t p0_adr,
  input  tcb_pkg::tcb_ben_t p0_ben,
  input  tcb_pkg::tcb_dat_t p0_wdt,
  output logic              p0_rsp_vld,
  output tcb_pkg::tcb_dat_t p0_rdt,
  output tcb_pkg::tcb_sts_t p0_sts,
  // port 1
  input  logic              p1_vld,
  output logic              p1_rdy,
  input  logic              p1_wen,
  input  tcb_pkg::tcb_adr_t p1_adr,
  input  tcb_pkg::tcb_ben_t p1_ben,
  input  tcb_pkg::tcb_dat_t p1_wdt,
  output logic              p1_rsp_vld,
  output tcb_pkg::tcb_dat_t p1_rdt,
  output tcb_pkg::tcb_sts_t p1_sts,
  // shared subordinate bus
  output logic              mem_vld,
  input  logic              mem_rdy,
  output logic              mem_wen,
  output tcb_pkg::tcb_adr_t mem_adr,
  output tcb_pkg::tcb_ben_t mem_ben,
  output tcb_pkg::tcb_dat_t mem_wdt,
  input  logic              mem_rsp_vld,
  input  tcb_pkg::tcb_dat_t mem_rdt,
  input  tcb_pkg::tcb_sts_t mem_sts
);

  import tcb_pkg::*;

  // set when port 1 is favoured on a tie
  logic rr_pri;
  // set when port 1 wins this cycle
  logic gnt_sel;
  // winner of the last handshake
  logic rsp_sel;

////////////////////////////////////////
// request
////////////////////////////////////////

  // port 1 wins alone or on a tie when it is favoured
  assign gnt_sel = p1_vld && (!p0_vld || rr_pri);

  assign mem_vld = p0_vld || p1_vld;
  assign p0_rdy  = mem_rdy && !gnt_sel;
  assign p1_rdy  = mem_rdy &&  gnt_sel;

  // request multiplexer
  assign mem_wen = gnt_sel ? p1_wen : p0_wen;
  assign mem_adr = gnt_sel ? p1_adr : p0_adr;
  assign mem_ben = gnt_sel ? p1_ben : p0_ben;
  assign mem_wdt = gnt_sel ? p1_wdt : p0_wdt;

  // pointer moves past the winner and the grant is kept for the response
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rr_pri  <= 1'b0;
      rsp_sel <= 1'b0;
    end else if (mem_vld && mem_rdy) begin
      rr_pri  <= ~gnt_sel;
      rsp_sel <= gnt_sel;
    end
  end

////////////////////////////////////////
// response
////////////////////////////////////////

  // steer to the port granted one cycle back
  assign p0_rsp_vld = mem_rsp_vld && !rsp_sel;
  assign p1_rsp_vld = mem_rsp_vld &&  rsp_sel;

  // idle port sees zero data and ok
  assign p0_rdt = rsp_sel ? '0 : mem_rdt;
  assign p1_rdt = rsp_sel ? mem_rdt : '0;
  assign p0_sts = rsp_sel ? tcb_sts_ok : mem_sts;
  assign p1_sts = rsp_sel ? mem_sts : tcb_sts_ok;

  // every mem handshake accepts exactly one requesting port
  one_port_hsk: assert property (@(posedge clk) disable iff (!arst_n)
    (mem_vld && mem_rdy) == ((p0_vld && p0_rdy) ^ (p1_vld && p1_rdy)));

  // subordinate answers exactly one cycle after a handshake
  rsp_after_hsk: assert property (@(posedge clk) disable iff (!arst_n)
    mem_rsp_vld |-> $past(mem_vld && mem_rdy));

endmodule

`default_nettype wire

// ==== hw/tcb_logsize2byteena.sv ====
////////////////////////////////////////
// log size to byte enable converter, one per manager
// request path is combinational, read data is
// realigned from the offset kept at the handshake
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tcb_logsize2byteena (
  input  logic             clk,
  input  logic             arst_n,
  // log size side, manager connects here
  input  logic             sub_vld,
  output logic             sub_rdy,
  input  logic             sub_wen,
  input  tcb_pkg::tcb_adr_t sub_adr,
  input  tcb_pkg::tcb_siz_t sub_siz,
  input  tcb_pkg::tcb_ndn_t sub_ndn,
  input  tcb_pkg::tcb_dat_t sub_wdt,
  output logic             sub_rsp_vld,
  output tcb_pkg::tcb_dat_t sub_rdt,
  output tcb_pkg::tcb_sts_t sub_sts,
  // byte enable side, toward the arbiter
  output logic             man_vld,
  input  logic             man_rdy,
  output logic             man_wen,
  output tcb_pkg::tcb_adr_t man_adr,
  output tcb_pkg::tcb_ben_t man_ben,
  output tcb_pkg::tcb_dat_t man_wdt,
  input  logic             man_rsp_vld,
  input  tcb_pkg::tcb_dat_t man_rdt,
  input  tcb_pkg::tcb_sts_t man_sts
);

  import tcb_pkg::*;

  // request offset and byte count
  tcb_off_t   req_off;
  logic [3:0] req_len;

  // copies taken at the handshake
  tcb_off_t   rsp_off;
  tcb_siz_t   rsp_siz;
  tcb_ndn_t   rsp_ndn;
  logic [3:0] rsp_len;

////////////////////////////////////////
// request
////////////////////////////////////////

  // handshake and plain fields pass through
  assign man_vld = sub_vld;
  assign sub_rdy = man_rdy;
  assign man_wen = sub_wen;
  // low bits kept, the memory drops them
  assign man_adr = sub_adr;

  assign req_off = sub_adr[$bits(tcb_off_t)-1:0];
  assign req_len = 4'd1 << sub_siz;

  // byte enables and write lane rotation
  always_comb begin
    tcb_off_t idx;
    tcb_off_t src;
    for (int unsigned i = 0; i < TCB_BEN; i++) begin
      // distance of lane i from the first byte, wraps in the word
      idx = tcb_off_t'(i) - req_off;
      man_ben[i] = ({2'b00, idx} < req_len);
      if (sub_ndn == tcb_big) begin
        src = tcb_off_t'(req_len - 4'd1) - tcb_off_t'(i) + req_off;
      end else begin
        src = idx;
      end
      man_wdt[8*i +: 8] = sub_wdt[8*src +: 8];
    end
  end

////////////////////////////////////////
// response
////////////////////////////////////////

  // keep offset, size and order for the read data
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_off <= '0;
      rsp_siz <= '0;
      rsp_ndn <= tcb_little;
    end else if (sub_vld && sub_rdy) begin
      rsp_off <= req_off;
      rsp_siz <= sub_siz;
      rsp_ndn <= sub_ndn;
    end
  end

  assign rsp_len = 4'd1 << rsp_siz;

  // inverse rotation, bytes above the size read as zero
  always_comb begin
    tcb_off_t src;
    for (int unsigned i = 0; i < TCB_BEN; i++) begin
      if (rsp_ndn == tcb_big) begin
        src = tcb_off_t'(rsp_len - 4'd1) - tcb_off_t'(i) + rsp_off;
      end else begin
        src = tcb_off_t'(i) + rsp_off;
      end
      if (i < rsp_len) begin
        sub_rdt[8*i +: 8] = man_rdt[8*src +: 8];
      end else begin
        sub_rdt[8*i +: 8] = 8'h00;
      end
    end
  end

  assign sub_rsp_vld = man_rsp_vld;
  assign sub_sts     = man_sts;

////////////////////////////////////////
// checks
////////////////////////////////////////

  // size code 3 has no meaning
  sub_siz_legal: assert property (@(posedge clk) disable iff (!arst_n)
    sub_vld |-> (sub_siz != 2'd3));

  // stalled request must not change
  sub_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (sub_vld && !sub_rdy) |=> (sub_vld && $stable({sub_wen, sub_adr, sub_siz, sub_ndn, sub_wdt})));

endmodule

`default_nettype wire

// ==== hw/tcb_pkg.sv ====
////////////////////////////////////////
// shared widths, types and status codes for the
// tightly coupled bus, imported by every RTL block
////////////////////////////////////////

`default_nettype none

package tcb_pkg;

////////////////////////////////////////
// bus geometry
////////////////////////////////////////

  // bytes per data word
  localparam int unsigned TCB_BEN = 4;

  // byte address
  typedef logic [32-1:0] tcb_adr_t;
  // data word
  typedef logic [8*TCB_BEN-1:0] tcb_dat_t;
  // one enable per byte lane
  typedef logic [TCB_BEN-1:0] tcb_ben_t;

  // log size: 0 byte, 1 half, 2 word, 3 illegal
  typedef logic [2-1:0] tcb_siz_t;
  // byte offset inside a word
  typedef logic [$clog2(TCB_BEN)-1:0] tcb_off_t;

////////////////////////////////////////
// encodings
////////////////////////////////////////

  // byte order of a single access
  typedef enum logic {
    tcb_little = 1'b0,
    tcb_big    = 1'b1
  } tcb_ndn_t;

  // response status
  typedef enum logic {
    tcb_sts_ok  = 1'b0,
    tcb_sts_err = 1'b1
  } tcb_sts_t;

endpackage

`default_nettype wire
